//--- cam_if.sv
// Camera description link
`default_nettype none
`timescale 1ns/100ps

interface cam_if;

  logic                  render_frame;
  ray_demo_pkg::vector_t e;
  ray_demo_pkg::vector_t u;
  ray_demo_pkg::vector_t v;
  ray_demo_pkg::vector_t w;
  // High while the input chain is shifting
  logic                  loading;

  // Top side, fed from the input scan chain
  modport src (
    output render_frame, e, u, v, w, loading
  );

  // Ray generator side
  modport dst (
    input render_frame, e, u, v, w, loading
  );

endinterface : cam_if

`default_nettype wire

//--- compile.f
ray_demo_pkg.sv
cam_if.sv
shifter.sv
shifter2.sv
ray_gen.sv
pixel_fifo.sv
pipedemo.sv
tb_pipedemo.sv

//--- pipedemo.sv
// Ray generator scan harness
`default_nettype none
`timescale 1ns/100ps

module pipedemo (
  input  logic clk,
  input  logic rst_n,
  input  logic scan_in,
  input  logic scan_en,
  input  logic scan_clr,
  input  logic scan_shift,
  input  logic scan_ld,
  output logic scan_out,
  output logic frame_busy
);

  logic [ray_demo_pkg::SHIFT_IN_W-1:0]  shift_in;
  logic [ray_demo_pkg::SHIFT_OUT_W-1:0] shift_out;

  logic                              pb_we;
  logic                              pb_full;
  logic                              head_valid;
  ray_demo_pkg::pixel_buffer_entry_t pb_data;
  ray_demo_pkg::pixel_buffer_entry_t head;

  cam_if cam ();

  shifter #(
    .WIDTH (ray_demo_pkg::SHIFT_IN_W),
    .INIT  ('0)
  ) inputs (
    .clk,
    .rst_n,
    .d   (scan_in),
    .en  (scan_en),
    .clr (scan_clr),
    .q   (shift_in)
  );

  // Camera fields straight off the input chain
  assign cam.render_frame = shift_in[ray_demo_pkg::RF_BIT];
  assign cam.e            = shift_in[ray_demo_pkg::E_LSB +: ray_demo_pkg::VEC_W];
  assign cam.u            = shift_in[ray_demo_pkg::U_LSB +: ray_demo_pkg::VEC_W];
  assign cam.v            = shift_in[ray_demo_pkg::V_LSB +: ray_demo_pkg::VEC_W];
  assign cam.w            = shift_in[ray_demo_pkg::W_LSB +: ray_demo_pkg::VEC_W];
  assign cam.loading      = scan_en;

  ray_gen rp (
    .clk,
    .rst_n,
    .cam        (cam.dst),
    .pb_full,
    .pb_we,
    .pb_data,
    .frame_busy
  );

  // scan_ld pops the head in the same cycle the output chain captures it
  pixel_fifo pb (
    .clk,
    .rst_n,
    .pb_we,
    .pb_data,
    .pop        (scan_ld),
    .pb_full,
    .head_valid,
    .head
  );

  assign shift_out = {head, head_valid};

  shifter2 #(
    .WIDTH (ray_demo_pkg::SHIFT_OUT_W)
  ) outputs (
    .clk,
    .rst_n,
    .d     (shift_out),
    .ld    (scan_ld),
    .shift (scan_shift),
    .q     (scan_out)
  );

endmodule : pipedemo

`default_nettype wire

//--- pixel_fifo.sv
// Pixel buffer FIFO
`default_nettype none
`timescale 1ns/100ps

module pixel_fifo (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              pb_we,
  input  ray_demo_pkg::pixel_buffer_entry_t pb_data,
  input  logic                              pop,
  output logic                              pb_full,
  output logic                              head_valid,
  output ray_demo_pkg::pixel_buffer_entry_t head
);

  ray_demo_pkg::pixel_buffer_entry_t mem [ray_demo_pkg::PB_DEPTH];

  logic [ray_demo_pkg::PB_PTR_W-1:0] wr_ptr;
  logic [ray_demo_pkg::PB_PTR_W-1:0] rd_ptr;
  logic [ray_demo_pkg::PB_CNT_W-1:0] count;
  logic                              pop_ok;

  assign head_valid = (count != '0);
  assign pop_ok     = pop && head_valid;
  // One slot stays free for the pixel still in the generator pipeline
  assign pb_full    = (count >= ray_demo_pkg::PB_CNT_W'(ray_demo_pkg::PB_FULL_LEVEL));

  // Empty reads hand out an all-zero entry
  assign head = head_valid ? mem[rd_ptr] : '0;

  always_ff @(posedge clk) begin
    if (pb_we) begin
      mem[wr_ptr] <= pb_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (pb_we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({pb_we, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The generator must have respected pb_full
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    pb_we |-> (count != ray_demo_pkg::PB_CNT_W'(ray_demo_pkg::PB_DEPTH))
  );

  a_no_pop_when_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pop && count == '0) |=> (count == ray_demo_pkg::PB_CNT_W'($past(pb_we)))
  );

endmodule : pixel_fifo

`default_nettype wire

//--- ray_demo_pkg.sv
// Ray demo shared definitions
`default_nettype none

package ray_demo_pkg;

  // One signed vector component, wraps on overflow
  typedef logic signed [31:0] coord_t;

  // x sits in the low word, z in the high word
  typedef struct packed {
    coord_t z;
    coord_t y;
    coord_t x;
  } vector_t;

  typedef logic [3:0] pix_t;

  // px in the low bits, point in the high bits
  typedef struct packed {
    vector_t point;
    pix_t    py;
    pix_t    px;
  } pixel_buffer_entry_t;

  // Screen size in pixels
  localparam int SCREEN_W = 4;
  localparam int SCREEN_H = 3;

  // Scan chain widths
  localparam int SHIFT_IN_W  = 385;
  localparam int SHIFT_OUT_W = 105;

  // Input chain field layout
  localparam int VEC_W  = 96;
  localparam int RF_BIT = 0;
  localparam int E_LSB  = 1;
  localparam int U_LSB  = 97;
  localparam int V_LSB  = 193;
  localparam int W_LSB  = 289;

  // Pixel buffer sizing
  localparam int PB_DEPTH      = 4;
  localparam int PB_FULL_LEVEL = 3;
  localparam int PB_PTR_W      = 2;
  localparam int PB_CNT_W      = 3;

endpackage : ray_demo_pkg

`default_nettype wire

//--- ray_gen.sv
// Image-plane ray generator
`default_nettype none
`timescale 1ns/100ps

module ray_gen (
  input  logic                              clk,
  input  logic                              rst_n,
  cam_if.dst                                cam,
  input  logic                              pb_full,
  output logic                              pb_we,
  output ray_demo_pkg::pixel_buffer_entry_t pb_data,
  output logic                              frame_busy
);

  localparam ray_demo_pkg::pix_t X_MAX = ray_demo_pkg::pix_t'(ray_demo_pkg::SCREEN_W - 1);
  localparam ray_demo_pkg::pix_t Y_MAX = ray_demo_pkg::pix_t'(ray_demo_pkg::SCREEN_H - 1);
  localparam ray_demo_pkg::coord_t X_MID = ray_demo_pkg::coord_t'(ray_demo_pkg::SCREEN_W / 2);
  localparam ray_demo_pkg::coord_t Y_MID = ray_demo_pkg::coord_t'(ray_demo_pkg::SCREEN_H / 2);

  function automatic ray_demo_pkg::vector_t vec_scale(input ray_demo_pkg::coord_t s,
                                                      input ray_demo_pkg::vector_t a);
    ray_demo_pkg::vector_t r;
    r.x = s * a.x;
    r.y = s * a.y;
    r.z = s * a.z;
    return r;
  endfunction

  function automatic ray_demo_pkg::vector_t vec_add4(input ray_demo_pkg::vector_t a,
                                                     input ray_demo_pkg::vector_t b,
                                                     input ray_demo_pkg::vector_t c,
                                                     input ray_demo_pkg::vector_t d);
    ray_demo_pkg::vector_t r;
    r.x = a.x + b.x + c.x + d.x;
    r.y = a.y + b.y + c.y + d.y;
    r.z = a.z + b.z + c.z + d.z;
    return r;
  endfunction

  logic [1:0]            phase;
  logic                  phase0;
  logic                  rf_prev;
  logic                  start;
  logic                  busy;
  logic                  all_issued;
  logic                  issue_blocked;
  logic                  issue;
  logic                  last_pix;
  logic                  last_write;
  ray_demo_pkg::pix_t    x;
  ray_demo_pkg::pix_t    y;
  ray_demo_pkg::vector_t e_q;
  ray_demo_pkg::vector_t u_q;
  ray_demo_pkg::vector_t v_q;
  ray_demo_pkg::vector_t w_q;

  logic                  s1_valid;
  ray_demo_pkg::pix_t    s1_px;
  ray_demo_pkg::pix_t    s1_py;
  ray_demo_pkg::coord_t  s1_u;
  ray_demo_pkg::coord_t  s1_v;
  logic                  s2_valid;
  ray_demo_pkg::pix_t    s2_px;
  ray_demo_pkg::pix_t    s2_py;
  ray_demo_pkg::vector_t s2_pu;
  ray_demo_pkg::vector_t s2_pv;

  // Free-running issue pacer, 0 1 2 0 ...
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 2'd0;
    end else begin
      phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
    end
  end

  assign phase0 = (phase == 2'd0);

  // Only a settled chain counts as a render_frame edge
  assign start         = !cam.loading && !busy && cam.render_frame && !rf_prev;
  assign issue_blocked = busy && !all_issued && pb_full;
  assign issue         = busy && !all_issued && phase0 && !issue_blocked;
  assign last_pix      = (x == X_MAX) && (y == Y_MAX);
  assign last_write    = pb_we && (pb_data.px == X_MAX) && (pb_data.py == Y_MAX);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_prev    <= 1'b0;
      busy       <= 1'b0;
      all_issued <= 1'b0;
      x          <= '0;
      y          <= '0;
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      pb_we      <= 1'b0;
    end else begin
      if (!cam.loading) begin
        rf_prev <= cam.render_frame;
      end
      if (start) begin
        busy       <= 1'b1;
        all_issued <= 1'b0;
        x          <= '0;
        y          <= '0;
      end else begin
        // Raster walk holds its place while blocked
        if (issue) begin
          if (last_pix) begin
            all_issued <= 1'b1;
          end else if (x == X_MAX) begin
            x <= '0;
            y <= y + 1'b1;
          end else begin
            x <= x + 1'b1;
          end
        end
        if (last_write) begin
          busy <= 1'b0;
        end
      end
      s1_valid <= issue;
      s2_valid <= s1_valid;
      pb_we    <= s2_valid;
    end
  end

  // Camera is captured at the frame start
  always_ff @(posedge clk) begin
    if (start) begin
      e_q <= cam.e;
      u_q <= cam.u;
      v_q <= cam.v;
      w_q <= cam.w;
    end
  end

  // Stage 1 centres the pixel, stage 2 scales, stage 3 sums
  always_ff @(posedge clk) begin
    s1_px         <= x;
    s1_py         <= y;
    s1_u          <= ray_demo_pkg::coord_t'(x) - X_MID;
    s1_v          <= ray_demo_pkg::coord_t'(y) - Y_MID;
    s2_px         <= s1_px;
    s2_py         <= s1_py;
    s2_pu         <= vec_scale(s1_u, u_q);
    s2_pv         <= vec_scale(s1_v, v_q);
    pb_data.px    <= s2_px;
    pb_data.py    <= s2_py;
    pb_data.point <= vec_add4(e_q, w_q, s2_pu, s2_pv);
  end

  assign frame_busy = busy;

  a_no_start_while_loading : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> !$past(cam.loading)
  );

  // A write leaves no other pixel behind it in the pipeline
  a_one_in_flight : assert property (
    @(posedge clk) disable iff (!rst_n)
    pb_we |-> (!s1_valid && !s2_valid)
  );

endmodule : ray_gen

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pipedemo \
  -f compile.f \
  -o sim_pipedemo

./obj_dir/sim_pipedemo | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"

//--- shifter.sv
// Serial-in scan register
`default_nettype none
`timescale 1ns/100ps

module shifter #(
  parameter int               WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             d,
  input  logic             en,
  input  logic             clr,
  output logic [WIDTH-1:0] q
);

  logic [WIDTH-1:0] q_next;

  // New bit enters at the MSB, everything moves toward bit 0
  always_comb begin
    q_next = q;
    if (clr) begin
      q_next = INIT;
    end else if (en) begin
      q_next = {d, q[WIDTH-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= INIT;
    end else begin
      q <= q_next;
    end
  end

endmodule : shifter

`default_nettype wire

//--- shifter2.sv
// Parallel-load scan register
`default_nettype none
`timescale 1ns/100ps

module shifter2 #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] d,
  input  logic             ld,
  input  logic             shift,
  output logic             q
);

  logic [WIDTH-1:0] sr;

  // Load has priority over shift
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr <= '0;
    end else if (ld) begin
      sr <= d;
    end else if (shift) begin
      sr <= {1'b0, sr[WIDTH-1:1]};
    end
  end

  // Bit 0 is always on the pin
  assign q = sr[0];

  // Whatever the pixel buffer hands over must be fully defined
  a_q_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(q)
  );

endmodule : shifter2

`default_nettype wire

//--- tb_pipedemo.sv
// Ray demo testbench
`default_nettype none
`timescale 1ns/100ps

module tb_pipedemo;

  localparam int PIXELS  = ray_demo_pkg::SCREEN_W * ray_demo_pkg::SCREEN_H;
  localparam int TIMEOUT = 4 * (ray_demo_pkg::SHIFT_IN_W + PIXELS * 110) + 4000;

  logic clk = 1'b0;
  logic rst_n;
  logic scan_in;
  logic scan_en;
  logic scan_clr;
  logic scan_shift;
  logic scan_ld;
  logic scan_out;
  logic frame_busy;

  ray_demo_pkg::vector_t cam_e;
  ray_demo_pkg::vector_t cam_u;
  ray_demo_pkg::vector_t cam_v;
  ray_demo_pkg::vector_t cam_w;
  logic [31:0]           lfsr = 32'h5bc28f43;
  int                    cycles = 0;
  int                    tests = 0;
  int                    checks = 0;
  int                    errors = 0;

  pipedemo i_dut (
    .clk,
    .rst_n,
    .scan_in,
    .scan_en,
    .scan_clr,
    .scan_shift,
    .scan_ld,
    .scan_out,
    .frame_busy
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_coord(output ray_demo_pkg::coord_t c);
    for (int i = 0; i < 32; i++) begin
      c[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Image-plane point E + W + u*U + v*V, centred on the screen
  function automatic ray_demo_pkg::vector_t expected_point(input int px, input int py);
    ray_demo_pkg::coord_t  du;
    ray_demo_pkg::coord_t  dv;
    ray_demo_pkg::vector_t p;
    du = px - ray_demo_pkg::SCREEN_W / 2;
    dv = py - ray_demo_pkg::SCREEN_H / 2;
    p.x = cam_e.x + cam_w.x + du * cam_u.x + dv * cam_v.x;
    p.y = cam_e.y + cam_w.y + du * cam_u.y + dv * cam_v.y;
    p.z = cam_e.z + cam_w.z + du * cam_u.z + dv * cam_v.z;
    return p;
  endfunction

  task automatic compare_entry(input string name, input ray_demo_pkg::pixel_buffer_entry_t exp,
                               input ray_demo_pkg::pixel_buffer_entry_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  // Bit 0 of the chain goes in first
  task automatic scan_load_camera(input logic rf);
    logic [ray_demo_pkg::SHIFT_IN_W-1:0] bits;
    bits = {cam_w, cam_v, cam_u, cam_e, rf};
    for (int i = 0; i < ray_demo_pkg::SHIFT_IN_W; i++) begin
      @(posedge clk);
      scan_en <= 1'b1;
      scan_in <= bits[i];
    end
    @(posedge clk);
    scan_en <= 1'b0;
    scan_in <= 1'b0;
  endtask

  task automatic read_pixel(output logic vld, output ray_demo_pkg::pixel_buffer_entry_t ent);
    logic [ray_demo_pkg::SHIFT_OUT_W-1:0] bits;
    @(posedge clk);
    scan_ld <= 1'b1;
    @(posedge clk);
    scan_ld    <= 1'b0;
    scan_shift <= 1'b1;
    for (int i = 0; i < ray_demo_pkg::SHIFT_OUT_W; i++) begin
      @(negedge clk);
      bits[i] = scan_out;
      if (i < ray_demo_pkg::SHIFT_OUT_W - 1) @(posedge clk);
    end
    @(posedge clk);
    scan_shift <= 1'b0;
    vld = bits[0];
    ent = bits[ray_demo_pkg::SHIFT_OUT_W-1:1];
  endtask

  task automatic wait_frame_busy(input string name, input logic level, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (frame_busy !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (frame_busy !== level) begin
      errors++;
      $display("%s: frame_busy did not go to %b within %0d cycles", name, level, limit);
    end
  endtask

  // Clearing the chain lets the next render_frame count as a new edge
  task automatic start_frame(input string name);
    @(posedge clk);
    scan_clr <= 1'b1;
    @(posedge clk);
    scan_clr <= 1'b0;
    scan_load_camera(1'b1);
    wait_frame_busy(name, 1'b1, 20);
  endtask

  task automatic collect_frame(input string name, input bit interleave);
    logic                              vld;
    ray_demo_pkg::pixel_buffer_entry_t act;
    ray_demo_pkg::pixel_buffer_entry_t exp;
    int                                got;
    int                                reads;
    got = 0;
    reads = 0;
    while (got < PIXELS && reads < 60) begin
      read_pixel(vld, act);
      reads++;
      if (vld) begin
        exp.px    = ray_demo_pkg::pix_t'(got % ray_demo_pkg::SCREEN_W);
        exp.py    = ray_demo_pkg::pix_t'(got / ray_demo_pkg::SCREEN_W);
        exp.point = expected_point(got % ray_demo_pkg::SCREEN_W, got / ray_demo_pkg::SCREEN_W);
        compare_entry(name, exp, act);
        got++;
      end else if (!interleave) begin
        errors++;
        $display("%s: empty read after %0d of %0d pixels", name, got, PIXELS);
      end
    end
    if (got < PIXELS) begin
      errors++;
      $display("%s: only %0d of %0d pixels came back", name, got, PIXELS);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("test %s: %s", name, (errors == err0) ? "passed" : "failed");
  endtask

  task automatic test_reset_state();
    logic                              vld;
    ray_demo_pkg::pixel_buffer_entry_t act;
    int                                err0;
    err0 = errors;
    read_pixel(vld, act);
    compare_bit("reset_state valid", 1'b0, vld);
    compare_entry("reset_state entry", '0, act);
    compare_bit("reset_state frame_busy", 1'b0, frame_busy);
    report_test("reset_state", err0);
  endtask

  task automatic test_config_no_frame();
    logic                              vld;
    ray_demo_pkg::pixel_buffer_entry_t act;
    int                                err0;
    err0 = errors;
    cam_e = '{x: 5, y: 6, z: 7};
    cam_u = '{x: 1, y: 0, z: 0};
    cam_v = '{x: 0, y: 1, z: 0};
    cam_w = '{x: 0, y: 0, z: 1};
    scan_load_camera(1'b0);
    repeat (20) @(negedge clk);
    compare_bit("config_no_frame frame_busy", 1'b0, frame_busy);
    read_pixel(vld, act);
    compare_bit("config_no_frame valid", 1'b0, vld);
    report_test("config_no_frame", err0);
  endtask

  task automatic test_unit_frame();
    int err0;
    err0 = errors;
    cam_e = '{x: 10, y: 20, z: 30};
    cam_u = '{x: 1, y: 0, z: 0};
    cam_v = '{x: 0, y: 1, z: 0};
    cam_w = '{x: 0, y: 0, z: 1};
    start_frame("unit_frame");
    // Generator stalls once the buffer holds its limit
    repeat (100) @(negedge clk);
    compare_bit("unit_frame stalled", 1'b1, frame_busy);
    collect_frame("unit_frame", 1'b0);
    wait_frame_busy("unit_frame", 1'b0, 20);
    report_test("unit_frame", err0);
  endtask

  task automatic test_lfsr_camera();
    int err0;
    err0 = errors;
    random_coord(cam_e.x);
    random_coord(cam_e.y);
    random_coord(cam_e.z);
    random_coord(cam_u.x);
    random_coord(cam_u.y);
    random_coord(cam_u.z);
    random_coord(cam_v.x);
    random_coord(cam_v.y);
    random_coord(cam_v.z);
    random_coord(cam_w.x);
    random_coord(cam_w.y);
    random_coord(cam_w.z);
    // Make sure signed wraparound is hit
    cam_u.y[31] = 1'b1;
    cam_v.z[31] = 1'b1;
    start_frame("lfsr_camera");
    // The first read can come before the first pixel lands
    collect_frame("lfsr_camera", 1'b1);
    wait_frame_busy("lfsr_camera", 1'b0, 20);
    report_test("lfsr_camera", err0);
  endtask

  task automatic test_interleaved_reads();
    int err0;
    err0 = errors;
    cam_e = '{x: -3, y: 100, z: 7};
    cam_u = '{x: 2, y: -1, z: 0};
    cam_v = '{x: 0, y: 3, z: -5};
    cam_w = '{x: 1, y: 1, z: 1};
    start_frame("interleaved_reads");
    collect_frame("interleaved_reads", 1'b1);
    wait_frame_busy("interleaved_reads", 1'b0, 20);
    report_test("interleaved_reads", err0);
  endtask

  task automatic test_retrigger();
    int err0;
    err0 = errors;
    cam_e = '{x: 0, y: 0, z: 0};
    cam_w = '{x: 9, y: -9, z: 4};
    // render_frame is still 1 from the last frame
    scan_load_camera(1'b1);
    repeat (20) @(negedge clk);
    compare_bit("retrigger held 1", 1'b0, frame_busy);
    scan_load_camera(1'b0);
    scan_load_camera(1'b1);
    wait_frame_busy("retrigger", 1'b1, 20);
    collect_frame("retrigger", 1'b1);
    wait_frame_busy("retrigger", 1'b0, 20);
    report_test("retrigger", err0);
  endtask

  initial begin
    rst_n      = 1'b0;
    scan_in    = 1'b0;
    scan_en    = 1'b0;
    scan_clr   = 1'b0;
    scan_shift = 1'b0;
    scan_ld    = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_config_no_frame();
    test_unit_frame();
    test_lfsr_camera();
    test_interleaved_reads();
    test_retrigger();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_pipedemo

`default_nettype wire
